// File: vlog.f
+incdir+include
logic/compress_format_pkg.sv
logic/packet_pkg.sv
logic/group_fifo.sv
logic/unit_decoder.sv
logic/packet_packer.sv
logic/ifmap_decompressor.sv
bench/decomp_properties.sv
bench/tb_ifmap_decompressor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_ifmap_decompressor -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Simulation PASSED" sim.log && echo "run ok" \
    || { echo "run failed, see sim.log"; exit 1; }

// File: bench/tb_ifmap_decompressor.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module tb_ifmap_decompressor;
    localparam int UNITS = `DECOMP_UNITS_PER_GROUP;
    localparam int UNIT_BITS = `DECOMP_ZERO_BITS + `DECOMP_VAL_BITS;
    localparam int INFO_BITS = $bits(compress_format_pkg::group_info_t);
    localparam int SLOTS = `DECOMP_PACKET_SLOTS;
    localparam int MEM_LATENCY = 3;
    // five short streams need well under a thousand cycles even with back-pressure
    localparam int TIMEOUT_CYCLES = 4000;
    localparam compress_format_pkg::mem_word_t FILLER = 64'h7000_0000_0000_0000;

    logic layer23_gated_clk = 1'b0;
    logic rst_n;
    logic start;
    logic ifmap_buffer_req;
    compress_format_pkg::mem_word_t mem_data = '0;
    logic mem_data_valid = 1'b0;
    logic mem_ack = 1'b0;
    logic mem_req;
    logic decompressor_ack;
    packet_pkg::decomp_packet_t decompress_packet;

    compress_format_pkg::mem_word_t stream_q[$];  // groups of the current stream in fetch order
    packet_pkg::decomp_packet_t exp_pkts[$];
    int due_q[$];                                   // cycle in which each fetched word returns
    compress_format_pkg::mem_word_t data_q[$];
    logic last_q[$];                                // word is the end group of the stream
    int mem_idx = 0;
    int end_cycle = -1;  // cycle in which the end group was on the bus
    int cyc = 0;
    int errors = 0;
    int assert_fails;

    ifmap_decompressor dut (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .mem_req           (mem_req),
        .decompressor_ack  (decompressor_ack),
        .decompress_packet (decompress_packet)
    );

    always #5 layer23_gated_clk = ~layer23_gated_clk;

    always @(posedge layer23_gated_clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // memory acks every request in its own cycle and returns the word a few cycles later
    always @(negedge layer23_gated_clk) begin
        mem_data_valid = 1'b0;
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            mem_data = data_q.pop_front();
            mem_data_valid = 1'b1;
            due_q.delete(0);
            if (last_q[0] && end_cycle < 0) begin
                end_cycle = cyc;
            end
            last_q.delete(0);
        end
        mem_ack = mem_req;
        if (mem_req) begin
            due_q.push_back(cyc + MEM_LATENCY);
            if (mem_idx < stream_q.size()) begin
                data_q.push_back(stream_q[mem_idx]);
                last_q.push_back(mem_idx == stream_q.size() - 1);
            end else begin
                // fetched past the end, the DUT must drop it
                data_q.push_back(FILLER | compress_format_pkg::mem_word_t'(mem_idx));
                last_q.push_back(1'b0);
            end
            mem_idx++;
        end
    end

    function automatic compress_format_pkg::mem_word_t make_group(input int eidx,
                                                                  input logic with_val);
        compress_format_pkg::mem_word_t w;
        w = '0;
        for (int u = 0; u < UNITS; u++) begin
            w[UNIT_BITS*u +: `DECOMP_ZERO_BITS] = $urandom_range(15);
            w[UNIT_BITS*u + `DECOMP_ZERO_BITS +: `DECOMP_VAL_BITS] = $urandom_range(255);
        end
        if (eidx < UNITS && !with_val && w[UNIT_BITS*eidx +: `DECOMP_ZERO_BITS] == 0) begin
            w[UNIT_BITS*eidx] = 1'b1;  // the end unit still gives one zero
        end
        w[`DECOMP_MEM_WORD_BITS-1] = with_val;
        w[`DECOMP_MEM_WORD_BITS-2 -: 3] = eidx;
        return w;
    endfunction

    // expands the stream by the zero-run rules and cuts it into eight-slot packets
    function automatic void build_expected();
        packet_pkg::element_t elems[$];
        packet_pkg::decomp_packet_t pkt;
        compress_format_pkg::group_info_t info;
        compress_format_pkg::compress_unit_t unit;
        int fill;
        exp_pkts.delete();
        foreach (stream_q[g]) begin
            info = stream_q[g][`DECOMP_MEM_WORD_BITS-1 -: INFO_BITS];
            for (int u = 0; u < UNITS; u++) begin
                unit = stream_q[g][UNIT_BITS*u +: UNIT_BITS];
                if (info.end_idx == `DECOMP_ALL_VALID_CODE || u < info.end_idx ||
                    (u == info.end_idx && info.end_with_val)) begin
                    repeat (unit.zero) elems.push_back('0);
                    elems.push_back(unit.val);
                end else if (u == info.end_idx) begin
                    repeat (unit.zero) elems.push_back('0);  // stream closes on zeros
                end
            end
        end
        pkt = '0;
        fill = 0;
        foreach (elems[e]) begin
            pkt.data[fill] = elems[e];
            pkt.valid_mask[fill] = 1'b1;
            fill++;
            if (fill == SLOTS || e == elems.size() - 1) begin
                pkt.packet_valid = 1'b1;
                pkt.last = (e == elems.size() - 1);
                exp_pkts.push_back(pkt);
                pkt = '0;
                fill = 0;
            end
        end
    endfunction

    task automatic check_packet(input string name, input int idx,
                                input packet_pkg::decomp_packet_t act);
        packet_pkg::decomp_packet_t seen;
        seen = act;
        for (int s = 0; s < SLOTS; s++) begin
            if (!seen.valid_mask[s]) begin
                seen.data[s] = '0;  // empty slots carry no data
            end
        end
        if (seen !== exp_pkts[idx]) begin
            errors++;
            $display("mismatch %s packet %0d: expected %h actual %h", name, idx,
                     exp_pkts[idx], seen);
        end
    endtask

    task automatic collect_packets(input string name, input int busy_pct);
        packet_pkg::decomp_packet_t held;
        logic holding;
        int got;
        holding = 1'b0;
        got = 0;
        while (got < exp_pkts.size()) begin
            @(negedge layer23_gated_clk);
            ifmap_buffer_req = ($urandom_range(99) >= busy_pct);
            if (end_cycle >= 0 && cyc > end_cycle && mem_req) begin
                errors++;
                $display("%s: mem_req is high after the end group was written", name);
            end
            if (holding && decompress_packet !== held) begin
                errors++;
                $display("%s: packet %0d changed while it was held", name, got);
            end
            holding = 1'b0;
            // decompressor_ack marks a presented packet and its valid bit is compared too
            if (decompressor_ack && ifmap_buffer_req) begin
                check_packet(name, got, decompress_packet);  // taken at the next edge
                got++;
            end else if (decompressor_ack) begin
                holding = 1'b1;
                held = decompress_packet;
            end
        end
    endtask

    // nothing may be fetched or presented while the block has no stream to work on
    task automatic check_idle(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge layer23_gated_clk);
            ifmap_buffer_req = 1'b1;
            if (mem_req !== 1'b0) begin
                errors++;
                $display("%s: mem_req is high while the block should be idle", name);
            end
            if (decompressor_ack !== 1'b0 || decompress_packet.packet_valid !== 1'b0) begin
                errors++;
                $display("%s: a packet was presented while the block should be idle", name);
            end
        end
    endtask

    task automatic run_stream(input string name, input int n_groups, input logic last_val,
                              input int last_idx, input int busy_pct);
        stream_q.delete();
        for (int g = 0; g < n_groups - 1; g++) begin
            stream_q.push_back(make_group(`DECOMP_ALL_VALID_CODE, $urandom_range(1)));
        end
        stream_q.push_back(make_group(last_idx, last_val));
        build_expected();
        mem_idx = 0;
        end_cycle = -1;
        @(negedge layer23_gated_clk);
        start = 1'b1;
        @(negedge layer23_gated_clk);
        start = 1'b0;
        collect_packets(name, busy_pct);
        check_idle(name, 20);
    endtask

    task automatic test_reset_state();
        check_idle("reset_state", 20);
    endtask

    task automatic test_single_group();
        run_stream("single_group", 1, 1'b1, 4, 0);  // every unit closes on its value
    endtask

    task automatic test_multi_group();
        run_stream("multi_group", 12, 1'b0, $urandom_range(4), 0);
    endtask

    task automatic test_backpressure();
        run_stream("backpressure", 10, $urandom_range(1), $urandom_range(4), 45);
    endtask

    task automatic test_stop_restart();
        run_stream("restart_first", 6, 1'b0, 2, 30);
        run_stream("restart_second", 5, 1'b1, $urandom_range(4), 0);
    endtask

    initial begin
        void'($urandom(53933));
        rst_n = 1'b0;
        start = 1'b0;
        ifmap_buffer_req = 1'b0;
        repeat (10) @(negedge layer23_gated_clk);
        rst_n = 1'b1;
        test_reset_state();
        test_single_group();
        test_multi_group();
        test_backpressure();
        test_stop_restart();
        assert_fails = dut.u_group_fifo.u_decomp_properties.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bench/decomp_properties.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module decomp_properties (
    input logic layer23_gated_clk,
    input logic rst_n,
    input logic start,
    input logic mem_req,
    input logic mem_ack,
    input logic head_valid,
    input logic head_pop
);
    localparam int DEPTH = `DECOMP_FIFO_DEPTH;

    int occupancy;  // entries fetched and not yet popped
    int fail_count = 0;

    // acked requests add an entry and pops retire one
    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else if (start) begin
            occupancy <= 0;  // a new stream starts from an empty buffer
        end else begin
            occupancy <= occupancy + int'(mem_req & mem_ack) - int'(head_pop);
        end
    end

    occupancy_bound: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        occupancy <= DEPTH)
    else begin
        $error("group buffer occupancy %0d is above its depth", occupancy);
        fail_count++;
    end

    // a full buffer must not ask memory for more groups
    no_req_when_full: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        occupancy == DEPTH |-> !mem_req)
    else begin
        $error("mem_req is high while the group buffer is full");
        fail_count++;
    end

    pop_needs_head: assert property (@(posedge layer23_gated_clk) disable iff (!rst_n)
        head_pop |-> head_valid)
    else begin
        $error("head_pop arrived while the group buffer was empty");
        fail_count++;
    end

endmodule

bind group_fifo decomp_properties u_decomp_properties (
    .layer23_gated_clk (layer23_gated_clk),
    .rst_n             (rst_n),
    .start             (start),
    .mem_req           (mem_req),
    .mem_ack           (mem_ack),
    .head_valid        (head_valid),
    .head_pop          (head_pop)
);

// File: logic/ifmap_decompressor.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module ifmap_decompressor (
    input  logic                           layer23_gated_clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           ifmap_buffer_req,
    input  compress_format_pkg::mem_word_t mem_data,
    input  logic                           mem_data_valid,
    input  logic                           mem_ack,
    output logic                           mem_req,
    output logic                           decompressor_ack,
    output packet_pkg::decomp_packet_t     decompress_packet
);
    localparam int UNITS     = `DECOMP_UNITS_PER_GROUP;
    localparam int UNIT_BITS = $bits(compress_format_pkg::compress_unit_t);
    localparam int INFO_BITS = $bits(compress_format_pkg::group_info_t);

    compress_format_pkg::mem_word_t head_word;
    logic head_valid;
    logic head_pop;
    compress_format_pkg::compress_unit_t [UNITS-1:0] head_units;  // unit 0 in the low bits
    compress_format_pkg::group_info_t head_info;
    logic group_is_end;
    packet_pkg::element_count_t [UNITS-1:0] unit_count;
    logic [UNITS-1:0] unit_has_val;

    assign head_units = head_word[UNITS*UNIT_BITS-1:0];
    assign head_info = head_word[`DECOMP_MEM_WORD_BITS-1 -: INFO_BITS];  // info in the top nibble
    assign group_is_end = head_info.end_idx !=
                          compress_format_pkg::end_idx_t'(`DECOMP_ALL_VALID_CODE);
    assign decompressor_ack = decompress_packet.packet_valid;

    group_fifo u_group_fifo (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .head_pop          (head_pop),
        .mem_req           (mem_req),
        .head_valid        (head_valid),
        .head_word         (head_word)
    );

    // one lane per unit, all decoding the head group in the same cycle
    for (genvar i = 0; i < UNITS; i++) begin : g_lane
        unit_decoder #(.LANE(i)) u_unit_decoder (
            .unit         (head_units[i]),
            .info         (head_info),
            .unit_count   (unit_count[i]),
            .unit_has_val (unit_has_val[i])
        );
    end

    packet_packer u_packet_packer (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .head_valid        (head_valid),
        .units             (head_units),
        .unit_count        (unit_count),
        .unit_has_val      (unit_has_val),
        .group_is_end      (group_is_end),
        .head_pop          (head_pop),
        .packet            (decompress_packet)
    );

endmodule

// File: logic/packet_packer.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module packet_packer (
    input  logic                       layer23_gated_clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       ifmap_buffer_req,
    input  logic                       head_valid,
    input  compress_format_pkg::compress_unit_t [`DECOMP_UNITS_PER_GROUP-1:0] units,
    input  packet_pkg::element_count_t [`DECOMP_UNITS_PER_GROUP-1:0]          unit_count,
    input  logic [`DECOMP_UNITS_PER_GROUP-1:0] unit_has_val,
    input  logic                       group_is_end,
    output logic                       head_pop,
    output packet_pkg::decomp_packet_t packet
);
    localparam int UNITS = `DECOMP_UNITS_PER_GROUP;
    localparam int SLOTS = `DECOMP_PACKET_SLOTS;

    packet_pkg::pack_state_e state;
    packet_pkg::pack_state_e state_next;
    packet_pkg::decomp_packet_t packet_base;
    packet_pkg::decomp_packet_t packet_next;
    packet_pkg::element_count_t fill;        // slots already used in the packet being built
    packet_pkg::element_count_t fill_next;
    packet_pkg::element_count_t base_fill;
    packet_pkg::element_count_t free_slots;
    packet_pkg::element_count_t take;
    packet_pkg::element_count_t new_fill;
    packet_pkg::group_pos_t offset;          // elements of the head group already packed
    packet_pkg::group_pos_t offset_next;
    packet_pkg::group_pos_t remaining;
    packet_pkg::group_pos_t [UNITS-1:0] unit_end;  // running sum of the lane counts
    logic handshake;
    logic advance;
    logic append;
    logic group_done;
    logic end_done;
    logic emit;

    always_comb begin
        packet_pkg::group_pos_t acc;
        acc = '0;
        for (int i = 0; i < UNITS; i++) begin
            acc = acc + packet_pkg::group_pos_t'(unit_count[i]);
            unit_end[i] = acc;  // one past the last element of unit i
        end
    end

    assign handshake = packet.packet_valid & ifmap_buffer_req;

    // packing also carries on in the cycle a held packet is taken, so there is no bubble
    assign advance = (state == packet_pkg::FILL) ||
                     (state == packet_pkg::HOLD && handshake && !packet.last);
    assign append = advance & head_valid;

    assign packet_base = (state == packet_pkg::HOLD) ? '0 : packet;
    assign base_fill   = (state == packet_pkg::HOLD) ? '0 : fill;
    assign free_slots  = packet_pkg::element_count_t'(SLOTS) - base_fill;

    assign remaining = unit_end[UNITS-1] - offset;
    assign take = (remaining < packet_pkg::group_pos_t'(free_slots)) ?
                  packet_pkg::element_count_t'(remaining) : free_slots;
    assign new_fill = base_fill + take;

    assign group_done = packet_pkg::group_pos_t'(take) == remaining;  // head group used up
    assign end_done   = append & group_done & group_is_end;
    assign emit       = (new_fill == packet_pkg::element_count_t'(SLOTS)) | end_done;
    assign head_pop   = append & group_done;

    // element e of the group is a value only where some unit ends on its val
    always_comb begin
        packet_pkg::group_pos_t elem;
        packet_next = packet_base;
        for (int s = 0; s < SLOTS; s++) begin
            elem = offset + packet_pkg::group_pos_t'(s) - packet_pkg::group_pos_t'(base_fill);
            if (packet_pkg::element_count_t'(s) >= base_fill &&
                packet_pkg::element_count_t'(s) < new_fill) begin
                packet_next.valid_mask[s] = 1'b1;
                packet_next.data[s] = '0;
                for (int i = 0; i < UNITS; i++) begin
                    if (unit_has_val[i] && elem == unit_end[i] - 1'b1) begin
                        packet_next.data[s] = units[i].val;
                    end
                end
            end
        end
        packet_next.packet_valid = emit && new_fill != '0;  // an empty tail is dropped
        packet_next.last = end_done && new_fill != '0;
    end

    always_comb begin
        state_next  = state;
        fill_next   = fill;
        offset_next = offset;
        case (state)
            packet_pkg::IDLE: begin
                if (head_valid) begin
                    state_next = packet_pkg::FILL;
                end
            end
            packet_pkg::FILL, packet_pkg::HOLD: begin
                if (state == packet_pkg::HOLD && handshake && packet.last) begin
                    state_next = packet_pkg::DONE;  // final packet taken
                end else if (append) begin
                    fill_next   = emit ? '0 : new_fill;
                    offset_next = group_done ? '0 : offset + packet_pkg::group_pos_t'(take);
                    if (emit) begin
                        state_next = (new_fill == '0) ? packet_pkg::DONE : packet_pkg::HOLD;
                    end else begin
                        state_next = packet_pkg::FILL;
                    end
                end else if (state == packet_pkg::HOLD && handshake) begin
                    fill_next  = '0;
                    state_next = packet_pkg::FILL;  // taken while the buffer is empty
                end
            end
            default: begin
                state_next = state;  // DONE waits for the next start
            end
        endcase
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= packet_pkg::IDLE;
            fill   <= '0;
            offset <= '0;
            packet <= '0;
        end else if (start) begin
            state  <= packet_pkg::IDLE;
            fill   <= '0;
            offset <= '0;
            packet <= '0;
        end else begin
            state  <= state_next;
            fill   <= fill_next;
            offset <= offset_next;
            if (append) begin
                packet <= packet_next;
            end else if (handshake) begin
                packet <= '0;  // accepted with nothing new to pack
            end
        end
    end

endmodule

// File: logic/unit_decoder.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module unit_decoder #(
    parameter int LANE = 0  // position of this unit inside the group
) (
    input  compress_format_pkg::compress_unit_t unit,
    input  compress_format_pkg::group_info_t    info,
    output packet_pkg::element_count_t          unit_count,
    output logic                                unit_has_val
);
    localparam compress_format_pkg::end_idx_t LANE_IDX = compress_format_pkg::end_idx_t'(LANE);

    logic is_end;
    logic full_unit;
    logic zero_tail;
    packet_pkg::element_count_t run_len;

    assign is_end = info.end_idx != compress_format_pkg::end_idx_t'(`DECOMP_ALL_VALID_CODE);

    // units ahead of the end index, and the end unit when it closes on val, expand fully
    assign full_unit = !is_end || (LANE_IDX < info.end_idx) ||
                       (LANE_IDX == info.end_idx && info.end_with_val);
    assign zero_tail = is_end && LANE_IDX == info.end_idx && !info.end_with_val;

    assign run_len = packet_pkg::element_count_t'(unit.zero);

    always_comb begin
        if (full_unit) begin
            unit_count   = run_len + 1'b1;  // zeros then the value
            unit_has_val = 1'b1;
        end else if (zero_tail) begin
            unit_count   = run_len;         // stream ends inside the zero run
            unit_has_val = 1'b0;
        end else begin
            unit_count   = '0;              // past the end of the stream
            unit_has_val = 1'b0;
        end
    end

endmodule

// File: logic/group_fifo.sv
`timescale 1ns/1ps
`include "decomp_settings.svh"

module group_fifo (
    input  logic                           layer23_gated_clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  compress_format_pkg::mem_word_t mem_data,
    input  logic                           mem_data_valid,
    input  logic                           mem_ack,
    input  logic                           head_pop,
    output logic                           mem_req,
    output logic                           head_valid,
    output compress_format_pkg::mem_word_t head_word
);
    localparam int IDX_BITS = $clog2(`DECOMP_FIFO_DEPTH);

    compress_format_pkg::mem_word_t entries [`DECOMP_FIFO_DEPTH];
    compress_format_pkg::fifo_ptr_t wr_ptr;     // next entry that memory data lands in
    compress_format_pkg::fifo_ptr_t fetch_ptr;  // counts requests that memory has acked
    compress_format_pkg::fifo_ptr_t rd_ptr;     // head entry seen by the packer
    compress_format_pkg::group_info_t wr_info;
    logic enable;
    logic fetch_full;
    logic fetch;
    logic wr_en;
    logic wr_is_end;
    logic pop;

    // the info nibble of the incoming word tells whether it closes the stream
    assign wr_info = mem_data[`DECOMP_MEM_WORD_BITS-1 -: $bits(compress_format_pkg::group_info_t)];
    assign wr_is_end = wr_info.end_idx !=
                       compress_format_pkg::end_idx_t'(`DECOMP_ALL_VALID_CODE);

    // once enable drops, words from requests still in flight are thrown away
    assign wr_en = enable & mem_data_valid;

    // full when every entry is either in flight or waiting to be popped
    assign fetch_full = (fetch_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                        (fetch_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);
    assign mem_req = enable & ~fetch_full;
    assign fetch = mem_req & mem_ack;  // ack comes back in the same cycle as the request

    assign head_valid = wr_ptr != rd_ptr;
    assign pop = head_pop & head_valid;
    assign head_word = entries[rd_ptr[IDX_BITS-1:0]];

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            fetch_ptr <= '0;
            rd_ptr    <= '0;
            enable    <= 1'b0;
        end else if (start) begin
            wr_ptr    <= '0;  // a new stream always starts from an empty buffer
            fetch_ptr <= '0;
            rd_ptr    <= '0;
            enable    <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wr_en && wr_is_end) begin
                enable <= 1'b0;  // the end group is in, stop fetching
            end
            if (fetch) begin
                fetch_ptr <= fetch_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // words arrive in request order, so they simply land at the write pointer
    always_ff @(posedge layer23_gated_clk) begin
        if (wr_en) begin
            entries[wr_ptr[IDX_BITS-1:0]] <= mem_data;
        end
    end

endmodule

// File: logic/packet_pkg.sv
`include "decomp_settings.svh"

package packet_pkg;

    typedef logic [`DECOMP_VAL_BITS-1:0] element_t;
    typedef logic [`DECOMP_PACKET_SLOTS-1:0] slot_mask_t;
    typedef logic [`DECOMP_ZERO_BITS:0] element_count_t;  // 0 to 16 elements of one unit

    // element position inside one group, up to five full units
    typedef logic [$clog2(`DECOMP_UNITS_PER_GROUP * (1 << `DECOMP_ZERO_BITS) + 1)-1:0] group_pos_t;

    typedef struct packed {
        logic                                  packet_valid;
        logic                                  last;        // carries the final element
        slot_mask_t                            valid_mask;  // low aligned
        element_t [`DECOMP_PACKET_SLOTS-1:0]   data;        // slot 0 in the low byte
    } decomp_packet_t;

    typedef enum logic [1:0] {IDLE, FILL, HOLD, DONE} pack_state_e;

endpackage

// File: logic/compress_format_pkg.sv
`include "decomp_settings.svh"

package compress_format_pkg;

    typedef logic [`DECOMP_MEM_WORD_BITS-1:0] mem_word_t;  // raw word as memory returns it
    typedef logic [`DECOMP_ZERO_BITS-1:0] zero_run_t;
    typedef logic [`DECOMP_VAL_BITS-1:0] unit_val_t;
    typedef logic [`DECOMP_END_IDX_BITS-1:0] end_idx_t;

    // unit i sits at bits 12i+11 down to 12i, zero run in the low nibble
    typedef struct packed {
        unit_val_t val;   // byte emitted after the zeros
        zero_run_t zero;  // count of zero bytes ahead of val
    } compress_unit_t;

    typedef struct packed {
        logic     end_with_val;  // end unit closes with its value rather than with zeros
        end_idx_t end_idx;       // index of the end unit, all ones if none
    } group_info_t;

    typedef logic [$clog2(`DECOMP_FIFO_DEPTH):0] fifo_ptr_t;  // msb is the wrap bit

endpackage

// File: include/decomp_settings.svh
`ifndef DECOMP_SETTINGS_SVH
`define DECOMP_SETTINGS_SVH

// one memory word carries exactly one compress group
`define DECOMP_MEM_WORD_BITS 64

// entries in the group buffer, sized to cover the memory latency
`define DECOMP_FIFO_DEPTH 16

`define DECOMP_UNITS_PER_GROUP 5  // five 12-bit units below the 4 info bits
`define DECOMP_ZERO_BITS 4        // zero run ahead of each value
`define DECOMP_VAL_BITS 8         // one byte element

// the global buffer takes eight elements per packet
`define DECOMP_PACKET_SLOTS 8

`define DECOMP_END_IDX_BITS 3     // end index field of the info bits

// end index of a group whose five units are all valid
`define DECOMP_ALL_VALID_CODE 7

`endif
